//--- Makefile
TOP = voter_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f tb.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -Wall --timescale 1ns/100ps \
		--top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir $(LOG)

//--- design/copy_store.sv
module copy_store import vote_pkg::*; #(
	parameter int N_COPIES = N_COPIES_DEF,
	parameter int MAX_LEN  = MAX_LEN_DEF,
	localparam int ID_W = $clog2(N_COPIES + 1),
	localparam int CW   = (N_COPIES > 1) ? $clog2(N_COPIES) : 1,
	localparam int AW   = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1,
	localparam int LW   = $clog2(MAX_LEN + 1)
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wr_en,
	input  logic [ID_W-1:0]     wr_copy,
	input  logic [AW-1:0]       wr_addr,
	input  byte_t               wr_data,
	input  logic                frame_end,
	input  logic                set_clear,
	input  logic [CW-1:0]       rd_copy,
	input  logic [AW-1:0]       rd_addr,
	output byte_t               rd_data,
	output logic [LW-1:0]       rd_len,
	output logic [N_COPIES-1:0] present,
	output logic [N_COPIES-1:0] pair_agree
);

	byte_t               mem [N_COPIES][MAX_LEN];
	logic [LW-1:0]       len [N_COPIES];
	logic [N_COPIES-1:0] mism [N_COPIES];	// symmetric, set once a byte differed
	logic [N_COPIES-1:0] diff;		// byte now written differs from copy j
	logic [LW-1:0]       cur_len;		// bytes of the copy being written
	logic [CW-1:0]       wr_idx;
	logic                first_wr;

	assign wr_idx   = CW'(wr_copy - 1'b1);	// ids start at 1
	assign first_wr = wr_en && (wr_addr == '0);
	assign rd_len   = len[rd_copy];

	always_comb begin
		for (int j = 0; j < N_COPIES; j++)
			diff[j] = present[j] && (CW'(j) != wr_idx) && (mem[j][wr_addr] != wr_data);
	end

	// ========================================================================
	// buffers and read port
	// ========================================================================

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_idx][wr_addr] <= wr_data;
		if (frame_end)
			len[wr_idx] <= cur_len;
		rd_data <= mem[rd_copy][rd_addr];	// one cycle read latency
	end

	// ========================================================================
	// presence and pairwise mismatch
	// ========================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			present <= '0;
			cur_len <= '0;
			for (int i = 0; i < N_COPIES; i++)
				mism[i] <= '0;
		end else if (set_clear) begin
			present <= '0;
			for (int i = 0; i < N_COPIES; i++)
				mism[i] <= '0;
		end else begin
			if (wr_en) begin
				cur_len <= cur_len + 1'b1;
				for (int j = 0; j < N_COPIES; j++) begin
					if (CW'(j) != wr_idx) begin
						if (first_wr) begin	// rewritten copy starts clean
							mism[wr_idx][j] <= diff[j];
							mism[j][wr_idx] <= diff[j];
						end else if (diff[j]) begin
							mism[wr_idx][j] <= 1'b1;
							mism[j][wr_idx] <= 1'b1;
						end
					end
				end
			end
			if (frame_end) begin
				present[wr_idx] <= 1'b1;
				cur_len         <= '0;
				if (cur_len == '0) begin	// empty rewrite, old marks are stale
					for (int j = 0; j < N_COPIES; j++) begin
						mism[wr_idx][j] <= 1'b0;
						mism[j][wr_idx] <= 1'b0;
					end
				end
			end
		end
	end

	// a copy agrees when some other present copy has the same length and no mismatch
	always_comb begin
		pair_agree = '0;
		for (int i = 0; i < N_COPIES; i++)
			for (int j = 0; j < N_COPIES; j++)
				if (i != j && present[i] && present[j] && len[i] == len[j] && !mism[i][j])
					pair_agree[i] = 1'b1;
	end

endmodule

//--- design/frame_capture.sv
module frame_capture import vote_pkg::*; #(
	parameter int N_COPIES  = N_COPIES_DEF,
	parameter int ID_OFFSET = ID_OFFSET_DEF,
	parameter int MAX_LEN   = MAX_LEN_DEF,
	localparam int ID_W  = $clog2(N_COPIES + 1),
	localparam int AW    = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1,
	localparam int CNT_W = $clog2(ID_OFFSET + MAX_LEN + 2)
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            rx_en,
	input  byte_t           rx_data,
	output logic            busy,		// registered rx_en
	output logic            wr_en,
	output logic [ID_W-1:0] wr_copy,
	output logic [AW-1:0]   wr_addr,
	output byte_t           wr_data,
	output logic            frame_end
);

	localparam logic [CNT_W-1:0] CNT_MAX = '1;

	byte_t            rx_data_q;
	logic [CNT_W-1:0] cnt;		// offset of rx_data_q within the frame
	logic             id_ok;	// id of this frame is in range
	logic             id_valid;
	logic             in_payload;
	logic [CNT_W-1:0] pay_idx;

	assign id_valid   = (rx_data_q != 8'd0) && (int'(rx_data_q) <= N_COPIES);
	assign in_payload = (int'(cnt) > ID_OFFSET) && (int'(cnt) <= ID_OFFSET + MAX_LEN);
	assign pay_idx    = cnt - CNT_W'(ID_OFFSET + 1);

	// input stage and write data path
	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
		wr_data   <= rx_data_q;
		wr_addr   <= AW'(pay_idx);
	end

	// ========================================================================
	// offset counter, id latch, strobes
	// ========================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			cnt       <= '0;
			id_ok     <= 1'b0;
			wr_copy   <= '0;
			wr_en     <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			busy      <= rx_en;
			wr_en     <= 1'b0;
			frame_end <= 1'b0;
			if (busy) begin
				if (cnt != CNT_MAX)
					cnt <= cnt + 1'b1;	// saturates past the longest payload
				if (int'(cnt) == ID_OFFSET) begin
					id_ok   <= id_valid;
					wr_copy <= ID_W'(rx_data_q);
				end else if (id_ok && in_payload) begin
					wr_en <= 1'b1;	// bytes beyond MAX_LEN are dropped
				end
			end else begin
				cnt       <= '0;
				frame_end <= id_ok;	// only frames with a usable id end a copy
				id_ok     <= 1'b0;
			end
		end
	end

endmodule

//--- design/replay_out.sv
module replay_out import vote_pkg::*; #(
	parameter int N_COPIES = N_COPIES_DEF,
	parameter int MAX_LEN  = MAX_LEN_DEF,
	localparam int CW = (N_COPIES > 1) ? $clog2(N_COPIES) : 1,
	localparam int AW = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1,
	localparam int LW = $clog2(MAX_LEN + 1)
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          play_start,
	input  logic [CW-1:0] play_copy,
	input  logic [LW-1:0] rd_len,
	input  byte_t         rd_data,
	output logic [CW-1:0] rd_copy,
	output logic [AW-1:0] rd_addr,
	output logic          en_out,
	output byte_t         data_out,
	output logic          play_done
);

	logic [CW-1:0] cpy_q;
	logic [AW-1:0] addr_q;
	logic [AW-1:0] last_addr;
	logic          running;	// read address being issued
	logic          fall_q;	// first cycle with en_out low again
	byte_t         hold_q;

	// length of the new copy is looked up in the play_start cycle
	assign rd_copy  = play_start ? play_copy : cpy_q;
	assign rd_addr  = addr_q;
	assign data_out = en_out ? rd_data : hold_q;	// line holds its last byte

	always_ff @(posedge clk) begin
		hold_q <= data_out;
		if (play_start)
			last_addr <= AW'(rd_len - 1'b1);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cpy_q     <= '0;
			addr_q    <= '0;
			running   <= 1'b0;
			en_out    <= 1'b0;
			fall_q    <= 1'b0;
			play_done <= 1'b0;
		end else begin
			en_out    <= running;	// lines up with the read latency
			fall_q    <= en_out && !running;
			play_done <= fall_q || (play_start && rd_len == '0);
			if (play_start) begin
				cpy_q   <= play_copy;
				addr_q  <= '0;
				running <= (rd_len != '0);
			end else if (running) begin
				if (addr_q == last_addr)
					running <= 1'b0;
				else
					addr_q <= addr_q + 1'b1;
			end
		end
	end

endmodule

//--- design/set_control.sv
module set_control import vote_pkg::*; #(
	parameter int N_COPIES    = N_COPIES_DEF,
	parameter int SET_TIMEOUT = SET_TIMEOUT_DEF,
	localparam int ID_W = $clog2(N_COPIES + 1),
	localparam int CW   = (N_COPIES > 1) ? $clog2(N_COPIES) : 1,
	localparam int IW   = $clog2(SET_TIMEOUT + 1)
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                frame_end,
	input  logic [ID_W-1:0]     wr_copy,
	input  logic                busy,
	input  logic [N_COPIES-1:0] present,
	input  logic [N_COPIES-1:0] pair_agree,
	input  logic                play_done,
	output logic                set_clear,
	output logic                play_start,
	output logic [CW-1:0]       play_copy,
	output logic                lost
);

	set_state_t    state;
	logic [IW-1:0] idle_cnt;	// idle cycles since the last frame
	logic          last_end;	// frame with the highest id just ended
	logic          timed_out;
	logic          close_set;
	logic [CW-1:0] pick;
	logic          found;

	assign last_end  = frame_end && (wr_copy == ID_W'(N_COPIES));
	assign timed_out = !busy && (present != '0) && (idle_cnt == IW'(SET_TIMEOUT - 1));
	assign close_set = last_end || timed_out;

	// lowest-numbered copy with a partner
	always_comb begin
		pick  = '0;
		found = 1'b0;
		for (int i = N_COPIES - 1; i >= 0; i--) begin
			if (pair_agree[i]) begin
				pick  = CW'(i);
				found = 1'b1;
			end
		end
	end

	// ========================================================================
	// set FSM
	// ========================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= st_collect;
			idle_cnt   <= '0;
			set_clear  <= 1'b0;
			play_start <= 1'b0;
			play_copy  <= '0;
			lost       <= 1'b0;
		end else begin
			set_clear  <= 1'b0;
			play_start <= 1'b0;
			lost       <= 1'b0;
			case (state)
				st_collect: begin
					if (busy || present == '0)
						idle_cnt <= '0;
					else
						idle_cnt <= idle_cnt + 1'b1;
					if (close_set) begin
						idle_cnt <= '0;
						state    <= st_vote;	// present settles this edge
					end
				end
				st_vote: begin
					set_clear <= 1'b1;
					if (found) begin
						play_start <= 1'b1;
						play_copy  <= pick;
						state      <= st_replay;
					end else begin
						lost  <= 1'b1;	// no two copies agree
						state <= st_collect;
					end
				end
				st_replay: begin
					if (play_done)
						state <= st_collect;
				end
				default: state <= st_collect;
			endcase
		end
	end

endmodule

//--- design/vote_pkg.sv
package vote_pkg;

	// ========================================================================
	// line data
	// ========================================================================

	typedef logic [7:0] byte_t;	// one byte on rx_data / data_out

	// ========================================================================
	// default set geometry, overridden on voter_top
	// ========================================================================

	localparam int N_COPIES_DEF    = 3;	// copies sent per packet
	localparam int ID_OFFSET_DEF   = 2;	// header bytes before the id
	localparam int MAX_LEN_DEF     = 64;	// payload bytes kept per copy
	localparam int SET_TIMEOUT_DEF = 32;	// idle cycles before an open set closes

	// ========================================================================
	// set controller states
	// ========================================================================

	typedef enum logic [1:0] {
		st_collect,	// copies arriving, idle timer running
		st_vote,	// agreement mask settled, pick a copy
		st_replay	// chosen copy streaming out
	} set_state_t;

endpackage

//--- design/voter_top.sv
module voter_top import vote_pkg::*; #(
	parameter int N_COPIES    = N_COPIES_DEF,
	parameter int ID_OFFSET   = ID_OFFSET_DEF,
	parameter int MAX_LEN     = MAX_LEN_DEF,
	parameter int SET_TIMEOUT = SET_TIMEOUT_DEF
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  rx_en,
	input  byte_t rx_data,
	output logic  en_out,
	output byte_t data_out,
	output logic  lost
);

	localparam int ID_W = $clog2(N_COPIES + 1);
	localparam int CW   = (N_COPIES > 1) ? $clog2(N_COPIES) : 1;
	localparam int AW   = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1;
	localparam int LW   = $clog2(MAX_LEN + 1);

	logic                busy;
	logic                wr_en;
	logic [ID_W-1:0]     wr_copy;
	logic [AW-1:0]       wr_addr;
	byte_t               wr_data;
	logic                frame_end;
	logic                set_clear;
	logic [N_COPIES-1:0] present;
	logic [N_COPIES-1:0] pair_agree;
	logic                play_start;
	logic [CW-1:0]       play_copy;
	logic                play_done;
	logic [CW-1:0]       rd_copy;
	logic [AW-1:0]       rd_addr;
	byte_t               rd_data;
	logic [LW-1:0]       rd_len;

	frame_capture #(.N_COPIES(N_COPIES), .ID_OFFSET(ID_OFFSET), .MAX_LEN(MAX_LEN)) u_capture (
		.clk(clk), .rst_n(rst_n), .rx_en(rx_en), .rx_data(rx_data), .busy(busy),
		.wr_en(wr_en), .wr_copy(wr_copy), .wr_addr(wr_addr), .wr_data(wr_data),
		.frame_end(frame_end)
	);

	copy_store #(.N_COPIES(N_COPIES), .MAX_LEN(MAX_LEN)) u_store (
		.clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_copy(wr_copy), .wr_addr(wr_addr),
		.wr_data(wr_data), .frame_end(frame_end), .set_clear(set_clear),
		.rd_copy(rd_copy), .rd_addr(rd_addr), .rd_data(rd_data), .rd_len(rd_len),
		.present(present), .pair_agree(pair_agree)
	);

	set_control #(.N_COPIES(N_COPIES), .SET_TIMEOUT(SET_TIMEOUT)) u_control (
		.clk(clk), .rst_n(rst_n), .frame_end(frame_end), .wr_copy(wr_copy), .busy(busy),
		.present(present), .pair_agree(pair_agree), .play_done(play_done),
		.set_clear(set_clear), .play_start(play_start), .play_copy(play_copy), .lost(lost)
	);

	replay_out #(.N_COPIES(N_COPIES), .MAX_LEN(MAX_LEN)) u_replay (
		.clk(clk), .rst_n(rst_n), .play_start(play_start), .play_copy(play_copy),
		.rd_len(rd_len), .rd_data(rd_data), .rd_copy(rd_copy), .rd_addr(rd_addr),
		.en_out(en_out), .data_out(data_out), .play_done(play_done)
	);

endmodule

//--- tb.f
design/vote_pkg.sv
design/frame_capture.sv
design/copy_store.sv
design/set_control.sv
design/replay_out.sv
design/voter_top.sv
tb/voter_chk.sv
tb/voter_tb.sv

//--- tb/voter_chk.sv
module voter_chk import vote_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input logic  en_out,
	input byte_t data_out,
	input logic  lost
);
	timeunit 1ns;
	timeprecision 100ps;

	logic played;	// a replay has put a byte on the line

	always_ff @(posedge clk) begin
		if (!rst_n)
			played <= 1'b0;
		else if (en_out)
			played <= 1'b1;
	end

	// ========================================================================
	// output protocol
	// ========================================================================

	lost_vs_en: assert property (@(posedge clk) disable iff (!rst_n) !(lost && en_out))
		else $error("lost and en_out high together");

	lost_pulse: assert property (@(posedge clk) disable iff (!rst_n) lost |=> !lost)
		else $error("lost high for more than one cycle");

	en_reset: assert property (@(posedge clk) !rst_n |=> !en_out)
		else $error("en_out high during or right after reset");

	hold_data: assert property (@(posedge clk) disable iff (!rst_n)
		(!en_out && played) |-> $stable(data_out))
		else $error("data_out moved while en_out low");

endmodule

bind voter_top voter_chk u_chk (
	.clk(clk), .rst_n(rst_n), .en_out(en_out), .data_out(data_out), .lost(lost)
);

//--- tb/voter_patterns.txt
// test mask frames ids ccopy cpos lcopy len start (all hex)
// ids: one nibble per frame, first frame highest; ccopy 0 = no corruption, lcopy gets 2 extra bytes
01 7 3 00123 0 00 0 0a 20
02 7 3 00123 1 04 0 0a 30
03 7 3 00123 3 09 0 0a 40
04 3 2 00012 0 00 0 10 50
05 3 2 00012 2 05 0 08 60
06 7 3 00123 1 02 3 0c 70
07 7 3 00123 0 00 2 0c 80
08 3 2 00012 0 00 1 06 90
09 7 5 05123 0 00 0 0e a0
0a 7 4 0f123 0 00 0 05 b0
0b 7 3 00123 0 00 2 40 c0
0c 7 3 00123 0 00 0 01 d0
0d 7 3 00213 0 00 0 07 e0
0e 7 3 00123 2 0b 0 0c f0
0f 5 2 00013 0 00 0 09 11
10 6 2 00023 3 00 0 09 22
11 1 1 00001 0 00 0 05 33
12 7 3 00123 0 00 3 3f 44
13 7 4 01123 0 00 0 08 55
14 3 3 00412 1 00 0 0b 66
15 7 3 00123 0 00 1 02 77
00 0 0 00000 0 00 0 00 00

//--- tb/voter_tb.sv
module voter_tb import vote_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_COPIES    = N_COPIES_DEF;
	localparam int ID_OFFSET   = ID_OFFSET_DEF;
	localparam int MAX_LEN     = MAX_LEN_DEF;
	localparam int SET_TIMEOUT = SET_TIMEOUT_DEF;
	localparam int MAX_TESTS   = 24;
	localparam int FIELDS      = 9;	// words per pattern line
	localparam int WAIT_LIMIT  = SET_TIMEOUT + 4 * MAX_LEN;
	// pattern columns
	localparam int F_NUM = 0, F_MASK = 1, F_NFR = 2, F_IDS = 3, F_CC = 4;
	localparam int F_CP = 5, F_XC = 6, F_LEN = 7, F_START = 8;

	logic                clk;
	logic                rst_n;
	logic                rx_en;
	byte_t               rx_data;
	logic                en_out;
	byte_t               data_out;
	logic                lost;

	logic [23:0]         pat [MAX_TESTS * FIELDS];
	byte_t               exp_mem [N_COPIES][MAX_LEN];	// reference copies of the set
	int                  exp_len [N_COPIES];
	logic [N_COPIES-1:0] exp_here;
	byte_t               got_q [$];
	int                  err_count;
	int                  test_count;
	int                  fail_count;
	bit                  hung;

	voter_top #(
		.N_COPIES(N_COPIES), .ID_OFFSET(ID_OFFSET), .MAX_LEN(MAX_LEN),
		.SET_TIMEOUT(SET_TIMEOUT)
	) dut (
		.clk(clk), .rst_n(rst_n), .rx_en(rx_en), .rx_data(rx_data),
		.en_out(en_out), .data_out(data_out), .lost(lost)
	);

	always #50 clk = ~clk;

	// ========================================================================
	// pattern decoding and reference model
	// ========================================================================

	function automatic int field(input int t, input int f);
		return int'(pat[t * FIELDS + f]);
	endfunction

	function automatic int frame_id(input int t, input int f);
		return (field(t, F_IDS) >> (4 * (field(t, F_NFR) - 1 - f))) & 15;	// first frame in top nibble
	endfunction

	function automatic int frame_len(input int t, input int id);
		if (id != 0 && id == field(t, F_XC))
			return field(t, F_LEN) + 2;	// the long copy
		return field(t, F_LEN);
	endfunction

	function automatic byte_t payload_byte(input int t, input int id, input int k);
		byte_t b;
		b = byte_t'(field(t, F_START) + k);
		if (id != 0 && id == field(t, F_CC) && k == field(t, F_CP))
			b = ~b;	// corrupted byte
		return b;
	endfunction

	task automatic build_model(input int t);
		int id;
		int len;
		exp_here = '0;
		for (int f = 0; f < field(t, F_NFR); f++) begin
			id = frame_id(t, f);
			if (id >= 1 && id <= N_COPIES) begin	// a repeated id overwrites
				len = frame_len(t, id);
				if (len > MAX_LEN)
					len = MAX_LEN;
				exp_here[id-1] = 1'b1;
				exp_len[id-1]  = len;
				for (int k = 0; k < len; k++)
					exp_mem[id-1][k] = payload_byte(t, id, k);
			end
		end
	endtask

	// lowest copy with a fully equal partner, -1 when none
	function automatic int pick_copy();
		bit same;
		for (int i = 0; i < N_COPIES; i++) begin
			for (int j = 0; j < N_COPIES; j++) begin
				if (i != j && exp_here[i] && exp_here[j] && exp_len[i] == exp_len[j]) begin
					same = 1'b1;
					for (int k = 0; k < exp_len[i]; k++)
						if (exp_mem[i][k] != exp_mem[j][k])
							same = 1'b0;
					if (same)
						return i;
				end
			end
		end
		return -1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("[ERROR] %s exp %0h got %0h", name, exp, got);
			err_count++;
		end
	endtask

	// ========================================================================
	// stimulus and response
	// ========================================================================

	task automatic send_frame(input int t, input int id);
		int total;
		total = ID_OFFSET + 1 + frame_len(t, id);
		for (int k = 0; k < total; k++) begin
			@(negedge clk);
			rx_en = 1'b1;
			if (k < ID_OFFSET)
				rx_data = byte_t'($urandom);	// header, ignored by the DUT
			else if (k == ID_OFFSET)
				rx_data = byte_t'(id);
			else
				rx_data = payload_byte(t, id, k - ID_OFFSET - 1);
		end
		@(negedge clk);
		rx_en   = 1'b0;
		rx_data = '0;
		repeat (2) @(negedge clk);	// 3 idle cycles between frames
	endtask

	task automatic run_test(input int t);
		int  pick;
		int  cycles;
		int  errs_before;
		bit  got_lost;
		errs_before = err_count;
		build_model(t);
		if (int'(exp_here) != field(t, F_MASK)) begin
			$display("test %0d: copy mask in the pattern does not match its ids", field(t, F_NUM));
			err_count++;
		end
		for (int f = 0; f < field(t, F_NFR); f++)
			send_frame(t, frame_id(t, f));
		pick     = pick_copy();
		got_lost = lost;
		cycles   = 0;
		while (!en_out && !got_lost && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			got_lost = lost;
			cycles++;
		end
		if (got_lost) begin
			if (pick >= 0) begin
				$display("test %0d: lost pulsed where a replay was expected", field(t, F_NUM));
				err_count++;
			end
			for (int c = 0; c < 8; c++) begin
				@(negedge clk);
				if (en_out) begin
					$display("test %0d: en_out rose after lost", field(t, F_NUM));
					err_count++;
					break;
				end
			end
		end else if (en_out) begin
			got_q.delete();
			cycles = 0;
			while (en_out && cycles <= MAX_LEN) begin
				got_q.push_back(data_out);
				@(negedge clk);
				cycles++;
			end
			if (en_out) begin
				$display("test %0d: en_out stuck high", field(t, F_NUM));
				err_count++;
				hung = 1'b1;
			end
			if (pick < 0) begin
				$display("test %0d: replay seen where lost was expected", field(t, F_NUM));
				err_count++;
			end else begin
				check_value("replay length", exp_len[pick], got_q.size());
				for (int k = 0; k < exp_len[pick] && k < got_q.size(); k++)
					check_value("data_out", exp_mem[pick][k], got_q[k]);
			end
		end else begin
			$display("test %0d: no en_out or lost within timeout", field(t, F_NUM));
			err_count++;
			hung = 1'b1;
		end
		repeat (6) @(negedge clk);	// play_done and return to collect
		test_count++;
		if (err_count == errs_before) begin
			$display("test %0d ok", field(t, F_NUM));
		end else begin
			$display("test %0d FAIL, %0d errors", field(t, F_NUM), err_count - errs_before);
			fail_count++;
		end
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================

	initial begin
		int t;
		void'($urandom(32'hc155));
		clk        = 1'b0;
		rst_n      = 1'b0;
		rx_en      = 1'b0;
		rx_data    = '0;
		err_count  = 0;
		test_count = 0;
		fail_count = 0;
		hung       = 1'b0;
		$readmemh("tb/voter_patterns.txt", pat);
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);
		t = 0;
		while (t < MAX_TESTS && !hung && !$isunknown(pat[t * FIELDS]) && field(t, F_NUM) != 0) begin
			run_test(t);
			t++;
		end
		$display("tests %0d, failing %0d, errors %0d", test_count, fail_count, err_count);
		if (err_count == 0 && !hung && test_count > 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
